// ==== files.f ====
src/pipeDefines.sv
src/memStage.sv
src/dataRam.sv
src/mem2Stage.sv
src/wbStage.sv
src/memPipeTop.sv
sim/memPipeTb.sv

// ==== sim/memPipeTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module memPipeTb;
    import pipeDefines::*;

    // upper bound on issued slots with bubbles, stall cycles and reset included
    localparam int INSTR_COUNT    = 300;
    localparam int TIMEOUT_CYCLES = 2 * INSTR_COUNT + 200;
    localparam word_t WINDOW      = 32'h0000_0200;   // random traffic area of 16 words

    typedef struct packed {
        logic     rw;      // mem2RegWrite
        excCode_t exc;
        word_t    pc;
        logic     chkRes;  // compare mem2Result and mem2Dst
        word_t    res;
        regAddr_t dst;
        logic     we;      // rfWe
        word_t    wbVal;
    } expect_t;

    logic     clk;
    logic     reset;
    logic     stall;
    logic     mem2Flush;
    logic     exValid;
    logic     exRegWrite;
    word_t    exAluOut;
    word_t    exPc;
    word_t    exOutB;
    regAddr_t exDst;
    wbSel_t   exWbSel;
    memOp_t   exMemOp;
    word_t    mem2Result;
    regAddr_t mem2Dst;
    logic     mem2RegWrite;
    excCode_t mem2Exc;
    word_t    mem2ExcPc;
    logic     rfWe;
    regAddr_t rfAddr;
    word_t    rfData;

    logic [31:0] lfsr;
    word_t       nextPc;
    int          cycleCount;
    logic [7:0]  memModel [word_t];   // byte-addressed reference memory
    expect_t     expQ [$];            // one entry per issued slot with the oldest first

    memPipeTop i_memPipeTop (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .mem2Flush    (mem2Flush),
        .exValid      (exValid),
        .exRegWrite   (exRegWrite),
        .exAluOut     (exAluOut),
        .exPc         (exPc),
        .exOutB       (exOutB),
        .exDst        (exDst),
        .exWbSel      (exWbSel),
        .exMemOp      (exMemOp),
        .mem2Result   (mem2Result),
        .mem2Dst      (mem2Dst),
        .mem2RegWrite (mem2RegWrite),
        .mem2Exc      (mem2Exc),
        .mem2ExcPc    (mem2ExcPc),
        .rfWe         (rfWe),
        .rfAddr       (rfAddr),
        .rfData       (rfData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", cycleCount);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        b;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
            r = {r[30:0], b};
        end
        return r;
    endfunction

    task automatic checkValue(input logic [127:0] actual, input logic [127:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s got %0h, expected %0h", $time, what, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "stopping at first error");
        end
    endtask

    function automatic logic [7:0] byteAt(input word_t a);
        return memModel.exists(a) ? memModel[a] : 8'hxx;
    endfunction

    function automatic void modelWrite(input memOp_t op, input word_t addr, input word_t data);
        word_t h;
        word_t w;
        int    i;
        h = {addr[31:1], 1'b0};
        w = {addr[31:2], 2'b00};
        case (op)
            MEM_SB: memModel[addr] = data[7:0];
            MEM_SH: begin
                memModel[h]     = data[7:0];
                memModel[h + 1] = data[15:8];
            end
            default: for (i = 0; i < 4; i++) memModel[w + i] = data[i*8 +: 8];
        endcase
    endfunction

    // little endian with extension per load kind
    function automatic word_t modelRead(input memOp_t op, input word_t addr);
        logic [7:0]  b;
        logic [15:0] h;
        word_t       w;
        b = byteAt(addr);
        h = {byteAt({addr[31:1], 1'b1}), byteAt({addr[31:1], 1'b0})};
        w = {addr[31:2], 2'b00};
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'd0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'd0, h};
            default: return {byteAt(w + 3), byteAt(w + 2), byteAt(w + 1), byteAt(w)};
        endcase
    endfunction

    function automatic logic [127:0] outputsNow();
        return {mem2Result, mem2Dst, mem2RegWrite, mem2Exc, mem2ExcPc, rfWe, rfAddr, rfData};
    endfunction

    // MEM2 holds the slot issued two steps back and WB the one three back
    task automatic compareOutputs();
        expect_t m2;
        expect_t wb;
        m2 = expQ[expQ.size() - 2];
        wb = expQ[expQ.size() - 3];
        checkValue(mem2RegWrite, m2.rw, "mem2RegWrite");
        checkValue(mem2Exc, m2.exc, "mem2Exc");
        if (m2.exc != EXC_NONE) checkValue(mem2ExcPc, m2.pc, "mem2ExcPc");
        if (m2.chkRes) begin
            checkValue(mem2Result, m2.res, "mem2Result");
            checkValue(mem2Dst, m2.dst, "mem2Dst");
        end
        checkValue(rfWe, wb.we, "rfWe");
        if (wb.we) begin
            checkValue(rfAddr, wb.dst, "rfAddr");
            checkValue(rfData, wb.wbVal, "rfData");
        end
    endtask

    task automatic issue(input logic valid, input logic regWrite, input word_t aluOut,
                         input word_t outB, input regAddr_t dst, input wbSel_t wbSel,
                         input memOp_t op, input logic flush);
        expect_t e;
        expect_t killed;
        logic    isStore;
        logic    misaligned;
        isStore    = 1'b0;
        misaligned = 1'b0;
        case (op)
            MEM_LH, MEM_LHU: misaligned = aluOut[0];
            MEM_LW:          misaligned = |aluOut[1:0];
            MEM_SB:          isStore = 1'b1;
            MEM_SH: begin
                isStore    = 1'b1;
                misaligned = aluOut[0];
            end
            MEM_SW: begin
                isStore    = 1'b1;
                misaligned = |aluOut[1:0];
            end
            default: ;
        endcase
        e = '0;
        e.dst = dst;
        e.pc  = nextPc;
        if (valid) begin
            if (misaligned) e.exc = isStore ? EXC_ADES : EXC_ADEL;
            e.rw     = regWrite & ~misaligned;
            e.chkRes = 1'b1;
            case (wbSel)
                WB_LINK: e.res = nextPc + LINK_OFFSET;
                WB_OUTB: e.res = outB;
                default: e.res = aluOut;   // loads show the address at MEM2
            endcase
            if (isStore && !misaligned) modelWrite(op, aluOut, outB);
            e.wbVal = (wbSel == WB_LOAD) ? modelRead(op, aluOut) : e.res;
            e.we    = e.rw && (dst != '0);
        end
        @(posedge clk);
        #1;
        compareOutputs();
        exValid    = valid;
        exRegWrite = regWrite;
        exAluOut   = aluOut;
        exPc       = nextPc;
        exOutB     = outB;
        exDst      = dst;
        exWbSel    = wbSel;
        exMemOp    = op;
        mem2Flush  = flush;
        if (flush) begin
            // the slot now in MEM never reaches MEM2
            killed        = expQ[expQ.size() - 1];
            killed.rw     = 1'b0;
            killed.exc    = EXC_NONE;
            killed.chkRes = 1'b0;
            killed.we     = 1'b0;
            expQ[expQ.size() - 1] = killed;
        end
        expQ.push_back(e);
        if (expQ.size() > 3) void'(expQ.pop_front());
        nextPc = nextPc + 4;
    endtask

    task automatic writeOp(input regAddr_t dst, input wbSel_t sel, input word_t aluOut,
                           input word_t outB);
        issue(1'b1, 1'b1, aluOut, outB, dst, sel, MEM_NONE, 1'b0);
    endtask

    task automatic storeOp(input memOp_t op, input word_t addr, input word_t data);
        issue(1'b1, 1'b0, addr, data, 5'd0, WB_LOAD, op, 1'b0);
    endtask

    task automatic loadOp(input memOp_t op, input regAddr_t dst, input word_t addr);
        issue(1'b1, 1'b1, addr, 32'd0, dst, WB_LOAD, op, 1'b0);
    endtask

    task automatic drain();
        repeat (3) issue(1'b0, 1'b0, 32'd0, 32'd0, 5'd0, WB_ALU, MEM_NONE, 1'b0);
    endtask

    task automatic holdStall(input int cycles);
        logic [127:0] frozen;
        expect_t      e;
        @(posedge clk);
        #1;
        compareOutputs();
        frozen    = outputsNow();
        exValid   = 1'b0;
        exMemOp   = MEM_NONE;
        mem2Flush = 1'b0;
        stall     = 1'b1;
        repeat (cycles) begin
            @(posedge clk);
            #1;
            compareOutputs();   // MEM2 and WB still hold the same slots
            checkValue(outputsNow(), frozen, "outputs during stall");
        end
        stall = 1'b0;
        e = '0;   // bubble enters EX/MEM once released
        expQ.push_back(e);
        if (expQ.size() > 3) void'(expQ.pop_front());
    endtask

    task automatic aluWrites();
        writeOp(5'd1, WB_ALU, 32'h1111_1111, 32'hffff_ffff);
        writeOp(5'd2, WB_ALU, randBits(32), 32'd0);
        writeOp(5'd0, WB_ALU, 32'h0000_5555, 32'd0);   // $zero gets no rf write
        writeOp(5'd31, WB_ALU, 32'h8000_0001, 32'd0);
        writeOp(5'd3, WB_ALU, 32'hdead_beef, 32'd0);
        drain();
    endtask

    task automatic linkAndMove();
        writeOp(5'd31, WB_LINK, 32'h0bad_0bad, 32'h1234_5678);
        writeOp(5'd4, WB_OUTB, 32'h0bad_0bad, 32'h1357_9bdf);
        writeOp(5'd5, WB_LINK, 32'd0, 32'd0);
        writeOp(5'd6, WB_OUTB, 32'd0, randBits(32));
        drain();
    endtask

    task automatic storeThenLoad();
        storeOp(MEM_SW, 32'h100, 32'h8899_aabb);
        storeOp(MEM_SW, 32'h104, 32'h0011_7f80);
        storeOp(MEM_SB, 32'h101, 32'h1234_56f0);   // only lane 1 changes
        storeOp(MEM_SH, 32'h106, 32'hcafe_8001);
        loadOp(MEM_LB, 5'd7, 32'h101);
        loadOp(MEM_LBU, 5'd8, 32'h101);
        loadOp(MEM_LB, 5'd9, 32'h104);
        loadOp(MEM_LH, 5'd10, 32'h106);
        loadOp(MEM_LHU, 5'd11, 32'h106);
        loadOp(MEM_LH, 5'd12, 32'h100);
        loadOp(MEM_LHU, 5'd13, 32'h102);
        loadOp(MEM_LW, 5'd14, 32'h100);
        loadOp(MEM_LW, 5'd15, 32'h104);
        drain();
    endtask

    task automatic misalignedAccess();
        storeOp(MEM_SW, 32'h140, 32'h0102_0304);
        storeOp(MEM_SH, 32'h141, 32'hffff_ffff);
        storeOp(MEM_SW, 32'h142, 32'hffff_ffff);
        loadOp(MEM_LH, 5'd16, 32'h143);
        loadOp(MEM_LW, 5'd17, 32'h141);
        loadOp(MEM_LHU, 5'd18, 32'h145);
        loadOp(MEM_LW, 5'd19, 32'h140);   // word must be untouched
        drain();
    endtask

    task automatic stallAndFlush();
        storeOp(MEM_SW, 32'h180, randBits(32));
        loadOp(MEM_LW, 5'd20, 32'h180);
        writeOp(5'd21, WB_ALU, 32'h0000_1234, 32'd0);
        loadOp(MEM_LBU, 5'd22, 32'h183);
        holdStall(4);
        loadOp(MEM_LH, 5'd23, 32'h182);
        writeOp(5'd24, WB_OUTB, 32'd0, 32'h4444_4444);
        drain();
        writeOp(5'd25, WB_ALU, 32'h5a5a_5a5a, 32'd0);
        issue(1'b0, 1'b0, 32'd0, 32'd0, 5'd0, WB_ALU, MEM_NONE, 1'b1);
        writeOp(5'd26, WB_ALU, 32'h6b6b_6b6b, 32'd0);
        loadOp(MEM_LW, 5'd27, 32'h181);   // would fault but gets flushed
        issue(1'b0, 1'b0, 32'd0, 32'd0, 5'd0, WB_ALU, MEM_NONE, 1'b1);
        drain();
    endtask

    function automatic word_t pickAddr(input int bytes);
        word_t a;
        a = WINDOW + {randBits(4), 2'b00};
        if (bytes == 1) a = a + randBits(2);
        else if (bytes == 2) a = a + {randBits(1), 1'b0};
        return a;
    endfunction

    task automatic randomTraffic();
        logic [1:0] kind;
        logic [2:0] sel;
        regAddr_t   dst;
        word_t      addr;
        word_t      data;
        int         i;
        for (i = 0; i < 16; i++) storeOp(MEM_SW, WINDOW + 4 * i, randBits(32));
        for (i = 0; i < 200; i++) begin
            kind = randBits(2);
            sel  = randBits(3);
            dst  = randBits(5);
            data = randBits(32);
            if (kind == 2'd0) begin
                writeOp(dst, WB_ALU, data, 32'd0);
            end else if (kind == 2'd1) begin
                case (sel % 3)
                    0:       storeOp(MEM_SB, pickAddr(1), data);
                    1:       storeOp(MEM_SH, pickAddr(2), data);
                    default: storeOp(MEM_SW, pickAddr(4), data);
                endcase
            end else begin
                case (sel % 5)
                    0:       loadOp(MEM_LB, dst, pickAddr(1));
                    1:       loadOp(MEM_LBU, dst, pickAddr(1));
                    2:       loadOp(MEM_LH, dst, pickAddr(2));
                    3:       loadOp(MEM_LHU, dst, pickAddr(2));
                    default: loadOp(MEM_LW, dst, pickAddr(4));
                endcase
            end
        end
        drain();
    endtask

    initial begin
        expect_t idle;
        reset      = 1'b1;
        stall      = 1'b0;
        mem2Flush  = 1'b0;
        exValid    = 1'b0;
        exRegWrite = 1'b0;
        exAluOut   = '0;
        exPc       = '0;
        exOutB     = '0;
        exDst      = '0;
        exWbSel    = WB_ALU;
        exMemOp    = MEM_NONE;
        lfsr       = 32'h2ff3;
        nextPc     = 32'h0040_0000;
        cycleCount = 0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        idle  = '0;
        repeat (3) expQ.push_back(idle);   // pipeline empty out of reset
        aluWrites();
        linkAndMove();
        storeThenLoad();
        misalignedAccess();
        stallAndFlush();
        randomTraffic();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/dataRam.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataRam (
    input  logic                  clk,
    input  logic                  ramEn,
    input  pipeDefines::byteEn_t  ramByteEn,
    input  pipeDefines::word_t    ramAddr,
    input  pipeDefines::word_t    ramWdata,
    output pipeDefines::word_t    ramRdata
);
    import pipeDefines::*;

    localparam int INDEX_BITS = $clog2(RAM_WORDS);

    word_t mem [RAM_WORDS];

    logic [INDEX_BITS-1:0] index;

    assign index = ramAddr[INDEX_BITS-1:0];   // upper address bits wrap

    // byte lane writes
    always_ff @(posedge clk) begin
        if (ramEn) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (ramByteEn[lane]) begin
                    mem[index][lane*8 +: 8] <= ramWdata[lane*8 +: 8];
                end
            end
        end
    end

    // a write in the same cycle still returns the old word
    always_ff @(posedge clk) begin
        if (ramEn) begin
            ramRdata <= mem[index];
        end
    end

endmodule

`default_nettype wire

// ==== src/mem2Stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem2Stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   mem2Flush,
    input  logic                   memValid,
    input  logic                   memRegWrite,
    input  pipeDefines::word_t     memAluOut,
    input  pipeDefines::word_t     memPc,
    input  pipeDefines::word_t     memOutB,
    input  pipeDefines::regAddr_t  memDst,
    input  pipeDefines::wbSel_t    memWbSel,
    input  pipeDefines::memOp_t    memMemOp,
    input  pipeDefines::excCode_t  memExc,
    output pipeDefines::word_t     mem2AluOut,
    output pipeDefines::word_t     mem2Pc,
    output pipeDefines::word_t     mem2OutB,
    output pipeDefines::regAddr_t  mem2Dst,
    output logic                   mem2RegWrite,
    output pipeDefines::wbSel_t    mem2WbSel,
    output pipeDefines::memOp_t    mem2MemOp,
    output pipeDefines::excCode_t  mem2Exc,
    output pipeDefines::word_t     mem2ExcPc,
    output pipeDefines::word_t     mem2Result
);
    import pipeDefines::*;

    // flush turns the slot into a bubble even while stalled
    always_ff @(posedge clk) begin
        if (reset || mem2Flush) begin
            mem2RegWrite <= 1'b0;
            mem2MemOp    <= MEM_NONE;
            mem2Exc      <= EXC_NONE;
        end else if (!stall) begin
            mem2RegWrite <= memRegWrite;
            mem2MemOp    <= memMemOp;
            mem2Exc      <= memValid ? memExc : EXC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            mem2AluOut <= memAluOut;
            mem2Pc     <= memPc;
            mem2OutB   <= memOutB;
            mem2Dst    <= memDst;
            mem2WbSel  <= memWbSel;
        end
    end

    // loads show the address here and their data only at wb
    always_comb begin
        case (mem2WbSel)
            WB_LINK: mem2Result = mem2Pc + LINK_OFFSET;
            WB_OUTB: mem2Result = mem2OutB;
            default: mem2Result = mem2AluOut;
        endcase
    end

    assign mem2ExcPc = (mem2Exc != EXC_NONE) ? mem2Pc : '0;

endmodule

`default_nettype wire

// ==== src/memPipeTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module memPipeTop (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   mem2Flush,
    input  logic                   exValid,
    input  logic                   exRegWrite,
    input  pipeDefines::word_t     exAluOut,
    input  pipeDefines::word_t     exPc,
    input  pipeDefines::word_t     exOutB,
    input  pipeDefines::regAddr_t  exDst,
    input  pipeDefines::wbSel_t    exWbSel,
    input  pipeDefines::memOp_t    exMemOp,
    output pipeDefines::word_t     mem2Result,  // for forwarding
    output pipeDefines::regAddr_t  mem2Dst,
    output logic                   mem2RegWrite,
    output pipeDefines::excCode_t  mem2Exc,
    output pipeDefines::word_t     mem2ExcPc,
    output logic                   rfWe,
    output pipeDefines::regAddr_t  rfAddr,
    output pipeDefines::word_t     rfData
);
    import pipeDefines::*;

    logic     ramEn;
    byteEn_t  ramByteEn;
    word_t    ramAddr;
    word_t    ramWdata;
    word_t    ramRdata;

    logic     memValid;
    logic     memRegWrite;
    word_t    memAluOut;
    word_t    memPc;
    word_t    memOutB;
    regAddr_t memDst;
    wbSel_t   memWbSel;
    memOp_t   memMemOp;
    excCode_t memExc;

    word_t    mem2AluOut;
    word_t    mem2Pc;
    word_t    mem2OutB;
    wbSel_t   mem2WbSel;
    memOp_t   mem2MemOp;

    memStage i_memStage (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .exValid     (exValid),
        .exRegWrite  (exRegWrite),
        .exAluOut    (exAluOut),
        .exPc        (exPc),
        .exOutB      (exOutB),
        .exDst       (exDst),
        .exWbSel     (exWbSel),
        .exMemOp     (exMemOp),
        .ramEn       (ramEn),
        .ramByteEn   (ramByteEn),
        .ramAddr     (ramAddr),
        .ramWdata    (ramWdata),
        .memValid    (memValid),
        .memRegWrite (memRegWrite),
        .memAluOut   (memAluOut),
        .memPc       (memPc),
        .memOutB     (memOutB),
        .memDst      (memDst),
        .memWbSel    (memWbSel),
        .memMemOp    (memMemOp),
        .memExc      (memExc)
    );

    dataRam i_dataRam (
        .clk       (clk),
        .ramEn     (ramEn),
        .ramByteEn (ramByteEn),
        .ramAddr   (ramAddr),
        .ramWdata  (ramWdata),
        .ramRdata  (ramRdata)
    );

    mem2Stage i_mem2Stage (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .mem2Flush    (mem2Flush),
        .memValid     (memValid),
        .memRegWrite  (memRegWrite),
        .memAluOut    (memAluOut),
        .memPc        (memPc),
        .memOutB      (memOutB),
        .memDst       (memDst),
        .memWbSel     (memWbSel),
        .memMemOp     (memMemOp),
        .memExc       (memExc),
        .mem2AluOut   (mem2AluOut),
        .mem2Pc       (mem2Pc),
        .mem2OutB     (mem2OutB),
        .mem2Dst      (mem2Dst),
        .mem2RegWrite (mem2RegWrite),
        .mem2WbSel    (mem2WbSel),
        .mem2MemOp    (mem2MemOp),
        .mem2Exc      (mem2Exc),
        .mem2ExcPc    (mem2ExcPc),
        .mem2Result   (mem2Result)
    );

    // read data lands in the MEM2 cycle and goes straight to wb
    wbStage i_wbStage (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .mem2AluOut   (mem2AluOut),
        .mem2Pc       (mem2Pc),
        .mem2OutB     (mem2OutB),
        .mem2Dst      (mem2Dst),
        .mem2RegWrite (mem2RegWrite),
        .mem2WbSel    (mem2WbSel),
        .mem2MemOp    (mem2MemOp),
        .mem2Result   (mem2Result),
        .ramRdata     (ramRdata),
        .rfWe         (rfWe),
        .rfAddr       (rfAddr),
        .rfData       (rfData)
    );

endmodule

`default_nettype wire

// ==== src/memStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module memStage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   exValid,
    input  logic                   exRegWrite,
    input  pipeDefines::word_t     exAluOut,
    input  pipeDefines::word_t     exPc,
    input  pipeDefines::word_t     exOutB,
    input  pipeDefines::regAddr_t  exDst,
    input  pipeDefines::wbSel_t    exWbSel,
    input  pipeDefines::memOp_t    exMemOp,
    output logic                   ramEn,
    output pipeDefines::byteEn_t   ramByteEn,
    output pipeDefines::word_t     ramAddr,
    output pipeDefines::word_t     ramWdata,
    output logic                   memValid,
    output logic                   memRegWrite,
    output pipeDefines::word_t     memAluOut,
    output pipeDefines::word_t     memPc,
    output pipeDefines::word_t     memOutB,
    output pipeDefines::regAddr_t  memDst,
    output pipeDefines::wbSel_t    memWbSel,
    output pipeDefines::memOp_t    memMemOp,
    output pipeDefines::excCode_t  memExc
);
    import pipeDefines::*;

    logic regWriteQ;
    logic isLoad;
    logic isStore;
    logic misaligned;

    // bubbles carry no memOp
    always_ff @(posedge clk) begin
        if (reset) begin
            memValid  <= 1'b0;
            regWriteQ <= 1'b0;
            memMemOp  <= MEM_NONE;
        end else if (!stall) begin
            memValid  <= exValid;
            regWriteQ <= exValid & exRegWrite;
            memMemOp  <= exValid ? exMemOp : MEM_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            memAluOut <= exAluOut;
            memPc     <= exPc;
            memOutB   <= exOutB;
            memDst    <= exDst;
            memWbSel  <= exWbSel;
        end
    end

    // access kind and alignment check
    always_comb begin
        isLoad     = 1'b0;
        isStore    = 1'b0;
        misaligned = 1'b0;
        case (memMemOp)
            MEM_LB, MEM_LBU: isLoad = 1'b1;
            MEM_LH, MEM_LHU: begin
                isLoad     = 1'b1;
                misaligned = memAluOut[0];
            end
            MEM_LW: begin
                isLoad     = 1'b1;
                misaligned = |memAluOut[1:0];
            end
            MEM_SB: isStore = 1'b1;
            MEM_SH: begin
                isStore    = 1'b1;
                misaligned = memAluOut[0];
            end
            MEM_SW: begin
                isStore    = 1'b1;
                misaligned = |memAluOut[1:0];
            end
            default: ;
        endcase
    end

    assign memExc = !misaligned ? EXC_NONE : (isStore ? EXC_ADES : EXC_ADEL);

    // a faulting instruction keeps moving but may not write anything
    assign memRegWrite = regWriteQ & (memExc == EXC_NONE);

    assign ramEn   = (isLoad | isStore) & ~misaligned & ~stall;
    assign ramAddr = {2'b00, memAluOut[31:2]};   // word address

    always_comb begin
        ramByteEn = '0;
        if (ramEn && isStore) begin
            case (memMemOp)
                MEM_SB:  ramByteEn = 4'b0001 << memAluOut[1:0];
                MEM_SH:  ramByteEn = memAluOut[1] ? 4'b1100 : 4'b0011;
                default: ramByteEn = 4'b1111;
            endcase
        end
    end

    // replicate so every lane sees the store data
    always_comb begin
        case (memMemOp)
            MEM_SB:  ramWdata = {4{memOutB[7:0]}};
            MEM_SH:  ramWdata = {2{memOutB[15:0]}};
            default: ramWdata = memOutB;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/pipeDefines.sv ====
`default_nettype none

package pipeDefines;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [3:0]  byteEn_t;
    typedef logic [1:0]  wbSel_t;
    typedef logic [3:0]  memOp_t;
    typedef logic [1:0]  excCode_t;

    // writeback / forwarding source
    localparam wbSel_t WB_LINK = 2'd0;   // pc + 8 for jal, jalr
    localparam wbSel_t WB_ALU  = 2'd1;
    localparam wbSel_t WB_OUTB = 2'd2;   // moves take operand b
    localparam wbSel_t WB_LOAD = 2'd3;   // data only known at wb

    // memory operations
    localparam memOp_t MEM_NONE = 4'd0;
    localparam memOp_t MEM_LB   = 4'd1;
    localparam memOp_t MEM_LBU  = 4'd2;
    localparam memOp_t MEM_LH   = 4'd3;
    localparam memOp_t MEM_LHU  = 4'd4;
    localparam memOp_t MEM_LW   = 4'd5;
    localparam memOp_t MEM_SB   = 4'd6;
    localparam memOp_t MEM_SH   = 4'd7;
    localparam memOp_t MEM_SW   = 4'd8;

    // address error exceptions
    localparam excCode_t EXC_NONE = 2'd0;
    localparam excCode_t EXC_ADEL = 2'd1;  // load or fetch
    localparam excCode_t EXC_ADES = 2'd2;  // store

    localparam int RAM_WORDS = 1024;

    localparam word_t LINK_OFFSET = 32'd8;

endpackage

`default_nettype wire

// ==== src/wbStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module wbStage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  pipeDefines::word_t     mem2AluOut,
    input  pipeDefines::word_t     mem2Pc,
    input  pipeDefines::word_t     mem2OutB,
    input  pipeDefines::regAddr_t  mem2Dst,
    input  logic                   mem2RegWrite,
    input  pipeDefines::wbSel_t    mem2WbSel,
    input  pipeDefines::memOp_t    mem2MemOp,
    input  pipeDefines::word_t     mem2Result,
    input  pipeDefines::word_t     ramRdata,
    output logic                   rfWe,
    output pipeDefines::regAddr_t  rfAddr,
    output pipeDefines::word_t     rfData
);
    import pipeDefines::*;

    logic [7:0]  loadByte;
    logic [15:0] loadHalf;
    word_t       loadData;
    word_t       wbData;

    // pick the addressed lane out of the returned word
    assign loadByte = ramRdata[{mem2AluOut[1:0], 3'b000} +: 8];
    assign loadHalf = mem2AluOut[1] ? ramRdata[31:16] : ramRdata[15:0];

    always_comb begin
        case (mem2MemOp)
            MEM_LB:  loadData = {{24{loadByte[7]}}, loadByte};
            MEM_LBU: loadData = {24'd0, loadByte};
            MEM_LH:  loadData = {{16{loadHalf[15]}}, loadHalf};
            MEM_LHU: loadData = {16'd0, loadHalf};
            default: loadData = ramRdata;   // lw
        endcase
    end

    // final source select
    always_comb begin
        case (mem2WbSel)
            WB_LOAD: wbData = loadData;
            WB_LINK: wbData = mem2Pc + LINK_OFFSET;
            WB_OUTB: wbData = mem2OutB;
            default: wbData = mem2Result;
        endcase
    end

    // $zero is hardwired and never written
    always_ff @(posedge clk) begin
        if (reset) begin
            rfWe <= 1'b0;
        end else if (!stall) begin
            rfWe <= mem2RegWrite & (mem2Dst != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rfAddr <= mem2Dst;
            rfData <= wbData;
        end
    end

endmodule

`default_nettype wire
